// File: design/cbOpPkg.sv
// CB opcode field positions, data byte and bit mask types, class and shift kind enums.
package cbOpPkg;

    // Opcode field positions.
    localparam int classMsb     = 7;
    localparam int classLsb     = 6;
    localparam int kindMsb      = 5;
    localparam int kindLsb      = 4;
    localparam int directionBit = 3; // 0 is left, 1 is right.
    localparam int indexMsb     = 5;
    localparam int indexLsb     = 3;

    typedef logic [7:0] byteT;
    typedef logic [7:0] bitMaskT; // One-hot, selects the addressed bit.

    // Instruction class, coded as opcode bits 7:6.
    typedef enum logic [classMsb-classLsb:0] {
        opShift = 2'b00,
        opBit   = 2'b01,
        opRes   = 2'b10,
        opSet   = 2'b11
    } opClassT;

    // Shift kind, coded as {kind, direction}. Code 110 has no kind of its own.
    typedef enum logic [2:0] {
        shRlc = 3'b000,
        shRl  = 3'b010,
        shRrc = 3'b001,
        shRr  = 3'b011,
        shSla = 3'b100,
        shSra = 3'b101,
        shSrl = 3'b111
    } shiftKindT;

endpackage

// File: design/flagPkg.sv
// Flag byte and write mask types, flag bit positions.
package flagPkg;

    typedef logic [7:0] flagT;

    // A set bit means that flag takes a new value.
    typedef logic [7:0] flagWriteMaskT;

    // Bit positions in the Z80 F register.
    localparam int flagS  = 7;
    localparam int flagZ  = 6;
    localparam int flagY  = 5; // Undocumented, always passed through.
    localparam int flagH  = 4;
    localparam int flagX  = 3; // Undocumented, always passed through.
    localparam int flagPv = 2;
    localparam int flagN  = 1;
    localparam int flagC  = 0;

endpackage

// File: design/cbDecoder.sv
// cbDecoder: CB opcode to class strobes, shift kind, bit mask and flag write mask.
`timescale 1ns/1ps

module cbDecoder (
    input  logic                  clk,
    input  cbOpPkg::byteT         opcode,
    output logic                  isShift,
    output logic                  isBit,
    output logic                  isRes,
    output logic                  isSet,
    output cbOpPkg::shiftKindT    shiftKind,
    output cbOpPkg::bitMaskT      bitMask,
    output flagPkg::flagWriteMaskT flagWriteMask
);

    cbOpPkg::opClassT opClass;
    logic             rightShift;
    logic [1:0]       kindField;
    logic [2:0]       bitIndex;

    assign opClass    = cbOpPkg::opClassT'(opcode[cbOpPkg::classMsb:cbOpPkg::classLsb]);
    assign rightShift = opcode[cbOpPkg::directionBit];
    assign kindField  = opcode[cbOpPkg::kindMsb:cbOpPkg::kindLsb];
    assign bitIndex   = opcode[cbOpPkg::indexMsb:cbOpPkg::indexLsb];

    assign isShift = (opClass == cbOpPkg::opShift);
    assign isBit   = (opClass == cbOpPkg::opBit);
    assign isRes   = (opClass == cbOpPkg::opRes);
    assign isSet   = (opClass == cbOpPkg::opSet);

    always_comb begin
        if (rightShift) begin
            case (kindField)
                2'b00:   shiftKind = cbOpPkg::shRrc;
                2'b01:   shiftKind = cbOpPkg::shRr;
                2'b10:   shiftKind = cbOpPkg::shSra;
                default: shiftKind = cbOpPkg::shSrl;
            endcase
        end else begin
            case (kindField)
                2'b00:   shiftKind = cbOpPkg::shRlc;
                2'b01:   shiftKind = cbOpPkg::shRl;
                default: shiftKind = cbOpPkg::shSla; // 1x, so 110 is SLA too.
            endcase
        end
    end

    assign bitMask = 8'h01 << bitIndex;

    always_comb begin
        flagWriteMask = '0; // RES and SET leave every flag alone.
        case (opClass)
            cbOpPkg::opShift: begin
                flagWriteMask[flagPkg::flagS]  = 1'b1;
                flagWriteMask[flagPkg::flagZ]  = 1'b1;
                flagWriteMask[flagPkg::flagH]  = 1'b1;
                flagWriteMask[flagPkg::flagPv] = 1'b1;
                flagWriteMask[flagPkg::flagN]  = 1'b1;
                flagWriteMask[flagPkg::flagC]  = 1'b1;
            end
            cbOpPkg::opBit: begin
                flagWriteMask[flagPkg::flagS]  = 1'b1;
                flagWriteMask[flagPkg::flagZ]  = 1'b1;
                flagWriteMask[flagPkg::flagH]  = 1'b1;
                flagWriteMask[flagPkg::flagPv] = 1'b1;
                flagWriteMask[flagPkg::flagN]  = 1'b1; // Carry is kept.
            end
            default: ;
        endcase
    end

    // The execute stage relies on a single class and a single tested bit.
    classOneHot: assert property (@(posedge clk)
        !$isunknown(opcode) |-> $onehot({isShift, isBit, isRes, isSet}) && $onehot(bitMask))
        else $error("decoder strobes or bit mask not one-hot for opcode %h", opcode);

endmodule

// File: design/rotateShiftUnit.sv
// rotateShiftUnit: RLC, RL, RRC, RR, SLA, SRA and SRL on one byte with carry out.
`timescale 1ns/1ps

module rotateShiftUnit (
    input  cbOpPkg::byteT      operand,
    input  cbOpPkg::shiftKindT shiftKind,
    input  logic               carryIn,
    output cbOpPkg::byteT      shiftResult,
    output logic               carryOut
);

    always_comb begin
        case (shiftKind)
            cbOpPkg::shRlc: begin
                shiftResult = {operand[6:0], operand[7]};
                carryOut    = operand[7];
            end
            cbOpPkg::shRl: begin
                shiftResult = {operand[6:0], carryIn}; // Old carry fills bit 0.
                carryOut    = operand[7];
            end
            cbOpPkg::shRrc: begin
                shiftResult = {operand[0], operand[7:1]};
                carryOut    = operand[0];
            end
            cbOpPkg::shRr: begin
                shiftResult = {carryIn, operand[7:1]}; // Old carry fills bit 7.
                carryOut    = operand[0];
            end
            cbOpPkg::shSla: begin
                shiftResult = {operand[6:0], 1'b0};
                carryOut    = operand[7];
            end
            cbOpPkg::shSra: begin
                shiftResult = {operand[7], operand[7:1]}; // Sign is kept.
                carryOut    = operand[0];
            end
            cbOpPkg::shSrl: begin
                shiftResult = {1'b0, operand[7:1]};
                carryOut    = operand[0];
            end
            default: begin
                // Not produced by the decoder.
                shiftResult = operand;
                carryOut    = carryIn;
            end
        endcase
    end

endmodule

// File: design/bitLogicUnit.sv
// bitLogicUnit: mask-based BIT test, RES clear and SET set on one byte.
`timescale 1ns/1ps

module bitLogicUnit (
    input  cbOpPkg::byteT    operand,
    input  cbOpPkg::bitMaskT bitMask,
    output cbOpPkg::byteT    resResult,
    output cbOpPkg::byteT    setResult,
    output logic             bitIsSet
);

    cbOpPkg::byteT maskedBit;

    // Only the addressed bit of the operand survives.
    assign maskedBit = operand & bitMask;

    // RES clears the addressed bit.
    assign resResult = operand & ~bitMask;

    // SET forces it high.
    assign setResult = operand | bitMask;

    // BIT leaves the operand and only reports the bit.
    assign bitIsSet = |maskedBit;

endmodule

// File: design/flagUnit.sv
// flagUnit: S, Z, H, PV, N and C for shifts and BIT, merged with incoming flags.
`timescale 1ns/1ps

module flagUnit (
    input  logic                   clk,
    input  logic                   isShift,
    input  logic                   isBit,
    input  cbOpPkg::byteT          shiftResult,
    input  logic                   carryOut,
    input  logic                   bitIsSet,
    input  cbOpPkg::bitMaskT       bitMask,
    input  flagPkg::flagWriteMaskT flagWriteMask,
    input  flagPkg::flagT          flagsIn,
    output flagPkg::flagT          nextFlags
);

    flagPkg::flagT shiftFlags;
    flagPkg::flagT bitFlags;
    flagPkg::flagT candidate;

    always_comb begin
        shiftFlags                  = '0;
        shiftFlags[flagPkg::flagS]  = shiftResult[7];
        shiftFlags[flagPkg::flagZ]  = (shiftResult == '0);
        shiftFlags[flagPkg::flagH]  = 1'b0;
        shiftFlags[flagPkg::flagPv] = ~^shiftResult; // Even parity.
        shiftFlags[flagPkg::flagN]  = 1'b0;
        shiftFlags[flagPkg::flagC]  = carryOut;
    end

    always_comb begin
        bitFlags                  = '0;
        bitFlags[flagPkg::flagS]  = bitMask[7] & bitIsSet; // Only bit 7 sets S.
        bitFlags[flagPkg::flagZ]  = ~bitIsSet;
        bitFlags[flagPkg::flagH]  = 1'b1;
        bitFlags[flagPkg::flagPv] = ~bitIsSet; // Same as Z.
        bitFlags[flagPkg::flagN]  = 1'b0;
    end

    always_comb begin
        if (isShift) begin
            candidate = shiftFlags;
        end else if (isBit) begin
            candidate = bitFlags;
        end else begin
            candidate = '0;
        end
    end

    // Each flag comes from the candidate only where the decoder allows it.
    assign nextFlags = (candidate & flagWriteMask) | (flagsIn & ~flagWriteMask);

    // X and Y are never touched by any class.
    xyKept: assert property (@(posedge clk)
        !$isunknown(flagsIn) |->
            nextFlags[flagPkg::flagX] == flagsIn[flagPkg::flagX] &&
            nextFlags[flagPkg::flagY] == flagsIn[flagPkg::flagY])
        else $error("X or Y flag changed, in %h out %h", flagsIn, nextFlags);

endmodule

// File: design/cbExecute.sv
// cbExecute: CB group execute stage with decoder, units and one-cycle output register.
`timescale 1ns/1ps

module cbExecute (
    input  logic          clk,
    input  logic          rstN,
    input  logic          opValid,
    input  cbOpPkg::byteT opcode,
    input  cbOpPkg::byteT operand,
    input  flagPkg::flagT flagsIn,
    output logic          resultValid,
    output logic          resultWrite,
    output cbOpPkg::byteT result,
    output flagPkg::flagT flagsOut
);

    logic                   isShift;
    logic                   isBit;
    logic                   isRes;
    logic                   isSet;
    cbOpPkg::shiftKindT     shiftKind;
    cbOpPkg::bitMaskT       bitMask;
    flagPkg::flagWriteMaskT flagWriteMask;
    cbOpPkg::byteT          shiftResult;
    logic                   carryOut;
    cbOpPkg::byteT          resResult;
    cbOpPkg::byteT          setResult;
    logic                   bitIsSet;
    flagPkg::flagT          nextFlags;
    cbOpPkg::byteT          selResult;

    cbDecoder decoder (
        .clk           (clk),
        .opcode        (opcode),
        .isShift       (isShift),
        .isBit         (isBit),
        .isRes         (isRes),
        .isSet         (isSet),
        .shiftKind     (shiftKind),
        .bitMask       (bitMask),
        .flagWriteMask (flagWriteMask)
    );

    rotateShiftUnit shifter (
        .operand     (operand),
        .shiftKind   (shiftKind),
        .carryIn     (flagsIn[flagPkg::flagC]),
        .shiftResult (shiftResult),
        .carryOut    (carryOut)
    );

    bitLogicUnit bitLogic (
        .operand   (operand),
        .bitMask   (bitMask),
        .resResult (resResult),
        .setResult (setResult),
        .bitIsSet  (bitIsSet)
    );

    flagUnit flags (
        .clk           (clk),
        .isShift       (isShift),
        .isBit         (isBit),
        .shiftResult   (shiftResult),
        .carryOut      (carryOut),
        .bitIsSet      (bitIsSet),
        .bitMask       (bitMask),
        .flagWriteMask (flagWriteMask),
        .flagsIn       (flagsIn),
        .nextFlags     (nextFlags)
    );

    always_comb begin
        if (isShift) begin
            selResult = shiftResult;
        end else if (isRes) begin
            selResult = resResult;
        end else if (isSet) begin
            selResult = setResult;
        end else begin
            selResult = operand; // BIT returns the operand unchanged.
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            resultWrite <= 1'b0;
            result      <= '0;
            flagsOut    <= '0;
        end else begin
            resultValid <= opValid;
            resultWrite <= opValid & ~isBit; // BIT never writes back.
            if (opValid) begin
                result   <= selResult;
                flagsOut <= nextFlags;
            end
        end
    end

    writeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        resultWrite |-> resultValid)
        else $error("resultWrite high without resultValid");

endmodule

// File: verification/cbRefModel.svh
// Reference model functions for the CB group and the Galois LFSR for stimulus.
`ifndef CB_REF_MODEL_SVH
`define CB_REF_MODEL_SVH

// 16-bit Galois LFSR, taps 16, 14, 13 and 11.
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    lfsrStep = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// Left kinds lose bit 7, right kinds lose bit 0.
function automatic logic shiftCarry(input logic [7:0] opcode, input logic [7:0] operand);
    shiftCarry = opcode[3] ? operand[0] : operand[7];
endfunction

function automatic logic [7:0] resultByte(input logic [7:0] opcode,
                                          input logic [7:0] operand,
                                          input logic       carry);
    logic [2:0] idx;
    logic [7:0] res;
    idx = opcode[5:3];
    res = operand;
    case (opcode[7:6])
        2'b00: begin
            case (idx)
                3'd0: res = {operand[6:0], operand[7]};  // RLC.
                3'd1: res = {operand[0], operand[7:1]};  // RRC.
                3'd2: res = {operand[6:0], carry};       // RL.
                3'd3: res = {carry, operand[7:1]};       // RR.
                3'd5: res = {operand[7], operand[7:1]};  // SRA.
                3'd7: res = {1'b0, operand[7:1]};        // SRL.
                default: res = {operand[6:0], 1'b0};     // SLA covers code 110 too.
            endcase
        end
        2'b01: res = operand;
        2'b10: res[idx] = 1'b0;
        default: res[idx] = 1'b1;
    endcase
    return res;
endfunction

function automatic logic [7:0] flagByte(input logic [7:0] opcode,
                                        input logic [7:0] operand,
                                        input logic [7:0] flagsIn);
    logic [7:0] res;
    logic       tested;
    flagByte = flagsIn; // RES and SET keep everything.
    res = resultByte(opcode, operand, flagsIn[flagPkg::flagC]);
    tested = operand[opcode[5:3]];
    if (opcode[7:6] == 2'b00) begin
        flagByte[flagPkg::flagS] = res[7];
        flagByte[flagPkg::flagZ] = (res == 8'h00);
        flagByte[flagPkg::flagH] = 1'b0;
        flagByte[flagPkg::flagPv] = (($countones(res) % 2) == 0);
        flagByte[flagPkg::flagN] = 1'b0;
        flagByte[flagPkg::flagC] = shiftCarry(opcode, operand);
    end else if (opcode[7:6] == 2'b01) begin
        flagByte[flagPkg::flagS] = tested && (opcode[5:3] == 3'd7);
        flagByte[flagPkg::flagZ] = !tested;
        flagByte[flagPkg::flagH] = 1'b1;
        flagByte[flagPkg::flagPv] = !tested;
        flagByte[flagPkg::flagN] = 1'b0;
    end
endfunction

`endif

// File: verification/cbExecuteTb.sv
// cbExecuteTb: random CB operations against the reference model, checked by assertions.
`timescale 1ns/1ps

module cbExecuteTb;

    localparam int maxCycles = 5000;

    logic       clk;
    logic       rstN;
    logic       opValid;
    logic [7:0] opcode;
    logic [7:0] operand;
    logic [7:0] flagsIn;
    logic       resultValid;
    logic       resultWrite;
    logic [7:0] result;
    logic [7:0] flagsOut;

    // Pending is what the next edge registers, expected is what the outputs show now.
    logic        pendValid;
    logic        pendWrite;
    logic        expValid;
    logic        expWrite;
    logic [7:0]  pendResult;
    logic [7:0]  pendFlags;
    logic [7:0]  expResult;
    logic [7:0]  expFlags;
    logic        checkOn;
    logic        prevValid;
    logic [15:0] lfsrState;
    int          hits[64]; // Opcode bits 7:3 with the carry in or the addressed bit.
    int          idleHits;
    int          backToBack;

    `include "cbRefModel.svh"

    cbExecute uut (
        .clk         (clk),
        .rstN        (rstN),
        .opValid     (opValid),
        .opcode      (opcode),
        .operand     (operand),
        .flagsIn     (flagsIn),
        .resultValid (resultValid),
        .resultWrite (resultWrite),
        .result      (result),
        .flagsOut    (flagsOut)
    );

    always #2 clk = ~clk;

    task automatic reportMismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] want);
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    validCheck: assert property (@(posedge clk) disable iff (!checkOn) resultValid == expValid)
        else reportMismatch("resultValid", $sampled(resultValid), $sampled(expValid));
    writeCheck: assert property (@(posedge clk) disable iff (!checkOn) resultWrite == expWrite)
        else reportMismatch("resultWrite", $sampled(resultWrite), $sampled(expWrite));
    resultCheck: assert property (@(posedge clk) disable iff (!checkOn) result == expResult)
        else reportMismatch("result", $sampled(result), $sampled(expResult));
    flagsCheck: assert property (@(posedge clk) disable iff (!checkOn) flagsOut == expFlags)
        else reportMismatch("flagsOut", $sampled(flagsOut), $sampled(expFlags));

    function automatic logic [7:0] randomBits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[6:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    function automatic logic allCovered();
        logic done;
        done = (idleHits > 0) && (backToBack > 0);
        foreach (hits[i])
            done &= (hits[i] > 0);
        return done;
    endfunction

    // One cycle of stimulus, 1 ns after the edge, with its expected outputs.
    task automatic driveCycle(input logic rstIn, input logic validIn, input logic [7:0] opIn,
                              input logic [7:0] dataIn, input logic [7:0] flagsVal);
        logic detail;
        @(posedge clk);
        #1;
        {expValid, expWrite, expResult, expFlags} = {pendValid, pendWrite, pendResult, pendFlags};
        rstN = rstIn;
        opValid = validIn;
        opcode = opIn;
        operand = dataIn;
        flagsIn = flagsVal;
        if (!rstIn) begin
            {pendValid, pendWrite, pendResult, pendFlags} = '0;
        end else begin
            pendValid = validIn;
            pendWrite = validIn && (opIn[7:6] != 2'b01); // BIT never writes.
            if (validIn) begin
                pendResult = resultByte(opIn, dataIn, flagsVal[flagPkg::flagC]);
                pendFlags = flagByte(opIn, dataIn, flagsVal);
                detail = (opIn[7:6] == 2'b00) ? flagsVal[flagPkg::flagC] : dataIn[opIn[5:3]];
                hits[{opIn[7:3], detail}]++;
            end else begin
                idleHits++;
            end
            if (validIn && prevValid)
                backToBack++;
        end
        prevValid = rstIn && validIn;
        checkOn = 1'b1;
    endtask

    task automatic randomCycle();
        logic [7:0] op;
        logic [7:0] data;
        logic [7:0] flags;
        logic [7:0] validBits;
        op = randomBits(8);
        data = randomBits(8);
        flags = randomBits(8);
        validBits = randomBits(2);
        driveCycle(1'b1, validBits[1:0] != 2'b00, op, data, flags);
    endtask

    initial begin
        int cycles;
        clk = 1'b0;
        rstN = 1'b0;
        opValid = 1'b0;
        opcode = '0;
        operand = '0;
        flagsIn = '0;
        lfsrState = 16'd46;
        {pendValid, pendWrite, pendResult, pendFlags} = '0;
        {expValid, expWrite, expResult, expFlags} = '0;
        checkOn = 1'b0;
        prevValid = 1'b0;
        idleHits = 0;
        backToBack = 0;
        foreach (hits[i])
            hits[i] = 0;
        repeat (3) driveCycle(1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
        cycles = 0;
        while (!allCovered()) begin
            if (cycles >= maxCycles) begin
                $display("timeout: not every CB function was reached in %0d cycles", cycles);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end else begin
                randomCycle();
                cycles++;
            end
        end
        repeat (2) driveCycle(1'b1, 1'b0, 8'h00, 8'h00, 8'h00); // Drain the last result.
        @(posedge clk);
        #1;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+verification
design/cbOpPkg.sv
design/flagPkg.sv
design/cbDecoder.sv
design/rotateShiftUnit.sv
design/bitLogicUnit.sv
design/flagUnit.sv
design/cbExecute.sv
verification/cbExecuteTb.sv

// File: Bender.yml
package:
  name: cbExecute

sources:
  - files:
      - design/cbOpPkg.sv
      - design/flagPkg.sv
      - design/cbDecoder.sv
      - design/rotateShiftUnit.sv
      - design/bitLogicUnit.sv
      - design/flagUnit.sv
      - design/cbExecute.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/cbExecuteTb.sv
